//--- build.f
hw/accel_core_pkg.sv
hw/weight_buffer.sv
hw/mul_controller.sv
hw/mac_unit.sv
hw/activation_buffer.sv
hw/accel_core.sv
sim/accel_core_checker.sv
sim/accel_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module accel_core_tb -f build.f -o accel_core_sim

./obj_dir/accel_core_sim | tee sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- sim/accel_core_tb.sv
`timescale 1ns/100ps

module accel_core_tb
    import accel_core_pkg::*;
();

    localparam int VEC_LEN        = 4;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40;
    localparam int LAYER_BOUND    = 2 * (VEC_LEN + 2) + 3;  // Cycles from layer_active rising

    logic                clock;
    logic                rst;
    logic                in_wr;
    elem_t               in_vec [VEC_LEN];
    logic                w_wr;
    buf_sel_t            w_sel;
    elem_t               w_vec [VEC_LEN];
    logic                layer_active;
    logic [NUM_WBUF-1:0] w_busy;
    acc_t                results [NUM_WBUF];
    logic [NUM_WBUF-1:0] result_valid;
    logic                layer_done;

    elem_t       x_ref [VEC_LEN];            // Expected input vector
    elem_t       w_ref [NUM_WBUF][VEC_LEN];  // Expected weight buffer contents
    logic [16:0] lfsr;
    int          cycles = 0;
    int          errors;
    int          tests_done;
    int          test_errors;

    accel_core #(.VEC_LEN(VEC_LEN)) i_accel_core (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // 17-bit Fibonacci LFSR, taps 17 and 14, one step per bit
    function automatic elem_t rand_elem();
        elem_t r;
        for (int b = 0; b < 8; b++) begin
            lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
            r[b] = lfsr[0];
        end
        return r;
    endfunction

    function automatic acc_t dot(input elem_t a [VEC_LEN], input elem_t b [VEC_LEN]);
        int s;
        s = 0;
        for (int j = 0; j < VEC_LEN; j++) begin
            s += int'(a[j]) * int'(b[j]);
        end
        return acc_t'(s);
    endfunction

    function automatic elem_t clamp(input acc_t v);
        if (v > 127) begin
            return 8'sd127;
        end else if (v < -128) begin
            return -8'sd128;
        end
        return elem_t'(v);
    endfunction

    task automatic report(input string name, input string what, input int expected,
                          input int actual);
        $display("error %s: %s expected %0d actual %0d", name, what, expected, actual);
        test_errors++;
    endtask

    task automatic complain(input string name, input string msg);
        $display("%s: %s", name, msg);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        $display("test %s done with %0d errors", name, test_errors);
        errors += test_errors;
        tests_done++;
        test_errors = 0;
    endtask

    task automatic drive_input();
        in_wr  = 1'b1;
        in_vec = x_ref;
        @(negedge clock);
        in_wr = 1'b0;
    endtask

    task automatic write_weight(input int k, input elem_t v [VEC_LEN]);
        w_wr  = 1'b1;
        w_sel = buf_sel_t'(k + 1);
        w_vec = v;
        @(negedge clock);
        w_wr = 1'b0;
    endtask

    task automatic load_weights();
        for (int k = 0; k < NUM_WBUF; k++) begin
            write_weight(k, w_ref[k]);
        end
    endtask

    // Runs one layer, checks it, then updates the model with the chained input
    task automatic run_layer(input string name);
        int    n;
        bit    cleared;
        acc_t  expected;
        elem_t chained [VEC_LEN];
        n = 0;
        cleared = 1'b0;
        layer_active = 1'b1;
        while (!(cleared && layer_done) && n <= LAYER_BOUND + 4) begin
            @(negedge clock);
            n++;
            if (result_valid == '0 && !layer_done) begin
                cleared = 1'b1;  // Old layer's status gone
            end
        end
        if (!cleared) begin
            complain(name, "result_valid was not cleared at layer start");
        end
        if (!layer_done) begin
            complain(name, "layer_done never rose");
        end else if (n > LAYER_BOUND) begin
            report(name, "cycles to layer_done", LAYER_BOUND, n);
        end
        if (result_valid != 3'b111) begin
            report(name, "result_valid", 7, result_valid);
        end
        chained = '{default: '0};
        for (int k = 0; k < NUM_WBUF; k++) begin
            expected = dot(x_ref, w_ref[k]);
            chained[k] = clamp(expected);
            if (results[k] !== expected) begin
                report(name, $sformatf("result %0d", k), expected, results[k]);
            end
        end
        repeat (2) @(negedge clock);  // Move lands two edges after layer_done
        layer_active = 1'b0;
        @(negedge clock);
        if (w_busy != '0) begin
            report(name, "w_busy after layer", 0, w_busy);
        end
        x_ref = chained;
    endtask

    task automatic test_reset();
        if (w_busy != '0) begin
            report("reset", "w_busy", 0, w_busy);
        end
        if (result_valid != '0) begin
            report("reset", "result_valid", 0, result_valid);
        end
        if (layer_done !== 1'b0) begin
            report("reset", "layer_done", 0, layer_done);
        end
        finish_test("reset");
    endtask

    task automatic test_single();
        x_ref    = '{1, 2, 3, 4};
        w_ref[0] = '{1, 1, 1, 1};
        w_ref[1] = '{2, -1, 0, 3};
        w_ref[2] = '{-5, 4, -3, 2};
        drive_input();
        load_weights();
        run_layer("single");
        finish_test("single");
    endtask

    task automatic test_busy_write();
        elem_t other [VEC_LEN];
        other    = '{9, 9, 9, 9};
        x_ref    = '{100, -50, 20, 7};  // Sums land outside the element range
        w_ref[0] = '{2, 0, 0, 0};
        w_ref[1] = '{-3, 0, 1, 0};
        w_ref[2] = '{0, 1, 0, 0};
        drive_input();
        load_weights();
        write_weight(1, other);  // W2 is loaded, so this write is dropped
        if (w_busy != 3'b111) begin
            report("busy_write", "w_busy", 7, w_busy);
        end
        run_layer("busy_write");
        finish_test("busy_write");
    endtask

    task automatic test_chain();
        w_ref[0] = '{1, 1, 1, 1};
        w_ref[1] = '{-1, 2, 3, 4};
        w_ref[2] = '{0, 0, 1, 5};
        load_weights();
        run_layer("chain");
        finish_test("chain");
    endtask

    task automatic test_random();
        for (int l = 0; l < 3; l++) begin
            for (int j = 0; j < VEC_LEN; j++) begin
                if (l != 2) begin
                    x_ref[j] = (l == 0) ? rand_elem() >>> 3 : rand_elem();
                end
                for (int k = 0; k < NUM_WBUF; k++) begin
                    w_ref[k][j] = rand_elem();
                end
            end
            if (l != 2) begin
                drive_input();  // Last layer runs on the chained input
            end
            load_weights();
            run_layer("random");
        end
        finish_test("random");
    endtask

    task automatic test_abort();
        for (int j = 0; j < VEC_LEN; j++) begin
            x_ref[j] = rand_elem() >>> 2;
            for (int k = 0; k < NUM_WBUF; k++) begin
                w_ref[k][j] = rand_elem() >>> 2;
            end
        end
        drive_input();
        load_weights();
        layer_active = 1'b1;
        repeat (10) @(negedge clock);  // W1 and W2 done, W3 in progress
        layer_active = 1'b0;
        repeat (8) begin
            @(negedge clock);
            if (layer_done) begin
                complain("abort", "layer_done rose after the layer was dropped");
            end
        end
        if (w_busy != 3'b100) begin
            report("abort", "w_busy after abort", 4, w_busy);
        end
        for (int k = 0; k < NUM_WBUF; k++) begin
            if (!w_busy[k]) begin
                write_weight(k, w_ref[k]);
            end
        end
        run_layer("abort");
        finish_test("abort");
    endtask

    initial begin
        rst          = 1'b1;
        in_wr        = 1'b0;
        in_vec       = '{default: '0};
        w_wr         = 1'b0;
        w_sel        = FREE;
        w_vec        = '{default: '0};
        layer_active = 1'b0;
        lfsr         = 17'd70642;
        errors       = 0;
        tests_done   = 0;
        test_errors  = 0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        test_reset();
        test_single();
        test_busy_write();
        test_chain();
        test_random();
        test_abort();

        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim/accel_core_checker.sv
`timescale 1ns/100ps

module accel_core_checker
    import accel_core_pkg::*;
(
    input logic                clock,
    input logic                rst,
    input mul_cmd_t            mul_cmd [2],
    input mul_result_t         mul_res [2],
    input logic [NUM_WBUF-1:0] release_w,
    input logic [NUM_WBUF-1:0] w_busy,
    input logic                layer_done,
    input logic                move_out_to_in
);

    // Two units never work on the same buffer
    a_distinct_sel: assert property (@(posedge clock) disable iff (rst)
        mul_cmd[0].sel == FREE || mul_cmd[0].sel != mul_cmd[1].sel)
        else $error("Both units hold buffer %0d", mul_cmd[0].sel);

    for (genvar i = 0; i < 2; i++) begin : g_unit
        a_clear_pulse: assert property (@(posedge clock) disable iff (rst)
            mul_cmd[i].clear |=> !mul_cmd[i].clear)
            else $error("Unit %0d clear longer than one cycle", i);
    end

    // Only a loaded buffer can be handed back, and only by its own unit
    for (genvar k = 0; k < NUM_WBUF; k++) begin : g_buf
        a_release_src: assert property (@(posedge clock) disable iff (rst)
            release_w[k] |-> w_busy[k] &&
                ((mul_res[0].valid && mul_res[0].sel == wbuf_sel(k)) ||
                 (mul_res[1].valid && mul_res[1].sel == wbuf_sel(k))))
            else $error("Buffer %0d released while idle or without a matching result", k);
    end

    // Move follows a rising layer_done by one cycle
    a_move_after_done: assert property (@(posedge clock) disable iff (rst)
        move_out_to_in |-> $past(layer_done) && !$past(layer_done, 2))
        else $error("move_out_to_in without a layer_done edge");

endmodule

bind accel_core accel_core_checker i_accel_core_checker (.*);

//--- hw/accel_core.sv
`timescale 1ns/100ps

module accel_core
    import accel_core_pkg::*;
#(
    parameter int VEC_LEN = 4
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                in_wr,
    input  elem_t               in_vec [VEC_LEN],
    input  logic                w_wr,
    input  buf_sel_t            w_sel,
    input  elem_t               w_vec [VEC_LEN],
    input  logic                layer_active,
    output logic [NUM_WBUF-1:0] w_busy,
    output acc_t                results [NUM_WBUF],
    output logic [NUM_WBUF-1:0] result_valid,
    output logic                layer_done
);

    elem_t               act_vec [VEC_LEN];        // Current layer input
    elem_t               wvecs [NUM_WBUF][VEC_LEN];
    logic [NUM_WBUF-1:0] release_w;
    mul_cmd_t            mul_cmd [2];
    mul_result_t         mul_res [2];
    logic                clear_output;
    logic                move_out_to_in;

    for (genvar k = 0; k < NUM_WBUF; k++) begin : g_wbuf
        weight_buffer #(.VEC_LEN(VEC_LEN)) i_weight_buffer (
            .clock     (clock),
            .rst       (rst),
            .wr        (w_wr && (w_sel == wbuf_sel(k))),
            .wdata     (w_vec),
            .release_w (release_w[k]),
            .in_use    (w_busy[k]),
            .wvec      (wvecs[k])
        );
    end

    for (genvar i = 0; i < 2; i++) begin : g_mac
        mac_unit #(.VEC_LEN(VEC_LEN)) i_mac_unit (
            .clock  (clock),
            .rst    (rst),
            .cmd    (mul_cmd[i]),
            .in_vec (act_vec),
            .wvecs  (wvecs),
            .result (mul_res[i])
        );
    end

    mul_controller i_mul_controller (
        .clock          (clock),
        .rst            (rst),
        .layer_active   (layer_active),
        .w_in_use       (w_busy),
        .layer_done     (layer_done),
        .cmd            (mul_cmd),
        .result         (mul_res),
        .release_w      (release_w),
        .clear_output   (clear_output),
        .move_out_to_in (move_out_to_in)
    );

    activation_buffer #(.VEC_LEN(VEC_LEN)) i_activation_buffer (
        .clock          (clock),
        .rst            (rst),
        .in_wr          (in_wr),
        .in_vec_host    (in_vec),
        .result         (mul_res),
        .clear_output   (clear_output),
        .move_out_to_in (move_out_to_in),
        .in_vec         (act_vec),
        .results        (results),
        .result_valid   (result_valid),
        .layer_done     (layer_done)
    );

endmodule

//--- hw/activation_buffer.sv
`timescale 1ns/100ps

module activation_buffer
    import accel_core_pkg::*;
#(
    parameter int VEC_LEN = 4
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                in_wr,
    input  elem_t               in_vec_host [VEC_LEN],
    input  mul_result_t         result [2],
    input  logic                clear_output,
    input  logic                move_out_to_in,
    output elem_t               in_vec [VEC_LEN],
    output acc_t                results [NUM_WBUF],
    output logic [NUM_WBUF-1:0] result_valid,
    output logic                layer_done
);

    // Clamp a sum to the element range
    function automatic elem_t saturate(input acc_t v);
        elem_t r;
        if (v > acc_t'(127)) begin
            r = 8'sd127;
        end else if (v < acc_t'(-128)) begin
            r = -8'sd128;
        end else begin
            r = v[7:0];
        end
        return r;
    endfunction

    // Input vector, written by the host or by the layer chaining move
    always_ff @(posedge clock) begin
        if (move_out_to_in) begin
            for (int j = 0; j < VEC_LEN; j++) begin
                in_vec[j] <= (j < NUM_WBUF) ? saturate(results[j]) : '0;
            end
        end else if (in_wr) begin
            in_vec <= in_vec_host;
        end
    end

    // Result slots, one per weight buffer
    always_ff @(posedge clock) begin
        for (int k = 0; k < NUM_WBUF; k++) begin
            for (int i = 0; i < 2; i++) begin
                if (result[i].valid && result[i].sel == wbuf_sel(k)) begin
                    results[k] <= result[i].value;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            result_valid <= '0;
            layer_done   <= 1'b0;
        end else begin
            if (clear_output) begin
                result_valid <= '0;  // New layer started
            end
            for (int k = 0; k < NUM_WBUF; k++) begin
                for (int i = 0; i < 2; i++) begin
                    if (result[i].valid && result[i].sel == wbuf_sel(k)) begin
                        result_valid[k] <= 1'b1;
                    end
                end
            end
            layer_done <= &result_valid;
        end
    end

endmodule

//--- hw/mac_unit.sv
`timescale 1ns/100ps

module mac_unit
    import accel_core_pkg::*;
#(
    parameter int VEC_LEN = 4
) (
    input  logic        clock,
    input  logic        rst,
    input  mul_cmd_t    cmd,
    input  elem_t       in_vec [VEC_LEN],
    input  elem_t       wvecs [NUM_WBUF][VEC_LEN],
    output mul_result_t result
);

    localparam int IW = $clog2(VEC_LEN);
    localparam logic [IW-1:0] LAST = IW'(VEC_LEN - 1);

    logic [IW-1:0]      idx;
    logic               run;   // Products still to add
    logic               vld;
    acc_t               acc;
    elem_t              w;
    logic signed [15:0] prod;

    // Weight element of the assigned buffer
    always_comb begin
        w = '0;
        for (int k = 0; k < NUM_WBUF; k++) begin
            if (cmd.sel == wbuf_sel(k)) begin
                w = wvecs[k][idx];
            end
        end
    end

    assign prod = w * in_vec[idx];

    always_ff @(posedge clock) begin
        if (rst) begin
            idx <= '0;
            run <= 1'b0;
            vld <= 1'b0;
        end else if (cmd.sel == FREE) begin  // Idle or aborted
            run <= 1'b0;
            vld <= 1'b0;
        end else if (cmd.clear) begin
            idx <= '0;
            run <= 1'b1;
            vld <= 1'b0;
        end else if (run) begin
            idx <= (idx == LAST) ? '0 : idx + 1'b1;
            run <= (idx != LAST);
            vld <= (idx == LAST);  // Pulse after the last product
        end else begin
            vld <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd.clear) begin
            acc <= '0;
        end else if (run) begin
            acc <= acc + acc_t'(prod);
        end
    end

    assign result.valid = vld && (cmd.sel != FREE);
    assign result.sel   = cmd.sel;
    assign result.value = acc;

endmodule

//--- hw/mul_controller.sv
`timescale 1ns/100ps

module mul_controller
    import accel_core_pkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  logic                layer_active,
    input  logic [NUM_WBUF-1:0] w_in_use,
    input  logic                layer_done,
    output mul_cmd_t            cmd [2],
    input  mul_result_t         result [2],
    output logic [NUM_WBUF-1:0] release_w,
    output logic                clear_output,
    output logic                move_out_to_in
);

    buf_sel_t asg [2];   // Current assignment per unit
    buf_sel_t nxt [2];
    logic     clr [2];
    logic     layer_active_q;
    logic     layer_done_q;

    // Lowest loaded buffer that is not excluded
    function automatic buf_sel_t pick(input logic [NUM_WBUF-1:0] avail,
                                      input buf_sel_t ex_a,
                                      input buf_sel_t ex_b);
        buf_sel_t s;
        buf_sel_t best;
        best = FREE;
        for (int k = NUM_WBUF - 1; k >= 0; k--) begin
            s = wbuf_sel(k);
            if (avail[k] && s != ex_a && s != ex_b) begin
                best = s;
            end
        end
        return best;
    endfunction

    always_comb begin
        nxt[0] = asg[0];
        if (!layer_active || result[0].valid) begin
            nxt[0] = FREE;
        end else if (asg[0] == FREE) begin
            nxt[0] = pick(w_in_use, asg[1], asg[1]);
        end

        // Unit 1 must avoid what unit 0 holds now and what it takes this cycle
        nxt[1] = asg[1];
        if (!layer_active || result[1].valid) begin
            nxt[1] = FREE;
        end else if (asg[1] == FREE) begin
            nxt[1] = pick(w_in_use, asg[0], nxt[0]);
        end
    end

    // Finished buffers are released in the valid cycle
    always_comb begin
        for (int k = 0; k < NUM_WBUF; k++) begin
            release_w[k] = (result[0].valid && result[0].sel == wbuf_sel(k)) ||
                           (result[1].valid && result[1].sel == wbuf_sel(k));
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 2; i++) begin
                asg[i] <= FREE;
                clr[i] <= 1'b0;
            end
            layer_active_q <= 1'b0;
            layer_done_q   <= 1'b0;
            clear_output   <= 1'b0;
            move_out_to_in <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                asg[i] <= nxt[i];
                clr[i] <= (asg[i] == FREE) && (nxt[i] != FREE);  // FREE to assigned
            end
            layer_active_q <= layer_active;
            layer_done_q   <= layer_done;
            clear_output   <= layer_active && !layer_active_q;
            move_out_to_in <= layer_done && !layer_done_q;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cmd[i].clear = clr[i];
            cmd[i].sel   = asg[i];
        end
    end

endmodule

//--- hw/weight_buffer.sv
`timescale 1ns/100ps

module weight_buffer
    import accel_core_pkg::*;
#(
    parameter int VEC_LEN = 4
) (
    input  logic  clock,
    input  logic  rst,
    input  logic  wr,
    input  elem_t wdata [VEC_LEN],
    input  logic  release_w,         // From the controller when the owner finishes
    output logic  in_use,
    output elem_t wvec [VEC_LEN]
);

    logic wr_ok;

    // A busy buffer silently drops host writes
    assign wr_ok = wr && !in_use;

    always_ff @(posedge clock) begin
        if (rst) begin
            in_use <= 1'b0;
        end else if (release_w) begin
            in_use <= 1'b0;
        end else if (wr_ok) begin
            in_use <= 1'b1;
        end
    end

    // Weight storage
    always_ff @(posedge clock) begin
        if (wr_ok) begin
            wvec <= wdata;
        end
    end

endmodule

//--- hw/accel_core_pkg.sv
package accel_core_pkg;

    // Number of weight buffers, one per neuron of the layer
    localparam int NUM_WBUF = 3;

    // Signed data element for inputs, weights and saturated outputs
    typedef logic signed [7:0] elem_t;

    // Wide enough for a dot product of up to 256 elements
    typedef logic signed [23:0] acc_t;

    // Weight buffer a unit works on, FREE when idle
    typedef enum logic [1:0] {
        FREE = 2'd0,
        W1   = 2'd1,
        W2   = 2'd2,
        W3   = 2'd3
    } buf_sel_t;

    // Controller to unit
    typedef struct packed {
        logic     clear;  // One cycle, starts a new dot product
        buf_sel_t sel;    // Stable while the unit works
    } mul_cmd_t;

    // Unit to controller and activation buffer
    typedef struct packed {
        logic     valid;  // One cycle pulse
        buf_sel_t sel;
        acc_t     value;
    } mul_result_t;

    // Maps a buffer index 0..2 to its select code
    function automatic buf_sel_t wbuf_sel(input int k);
        return buf_sel_t'(k + 1);
    endfunction

endpackage
